// File: src/usb_ahb_pkg.sv
// register map, transfer size, command and pid enums, bus request and endpoint status structs
package usb_ahb_pkg;

    // bus widths
    localparam int ADDR_W = 4;
    localparam int DATA_W = 32;

    // register map, byte addresses
    // data buffer window 0 to 3
    localparam logic [ADDR_W-1:0] REG_DATA = 4'd0;
    // status window 4 to 5
    localparam logic [ADDR_W-1:0] REG_STATUS = 4'd4;
    // error window 6 to 7
    localparam logic [ADDR_W-1:0] REG_ERROR = 4'd6;
    // buffer occupancy, single byte
    localparam logic [ADDR_W-1:0] REG_OCC = 4'd8;
    // 9 to 11 unused
    localparam logic [ADDR_W-1:0] REG_TX_CTRL = 4'd12;
    localparam logic [ADDR_W-1:0] REG_FLUSH = 4'd13;
    // 14 to 15 unused

    // transfer size as seen on hsize
    // code 0 selects no lanes
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd1,
        SIZE_HALF = 2'd2,
        SIZE_WORD = 2'd3
    } hsize_e;

    // commands towards the transmitter
    typedef enum logic [2:0] {
        TX_NONE  = 3'd0,
        TX_DATA  = 3'd1,
        TX_ACK   = 3'd2,
        TX_NAK   = 3'd3,
        TX_STALL = 3'd4
    } tx_cmd_e;

    // packet ids reported by the receiver
    typedef enum logic [2:0] {
        RX_OUT = 3'd1,
        RX_IN  = 3'd2,
        RX_ACK = 3'd5,
        RX_NAK = 3'd6
    } rx_pid_e;

    // one ahb-lite address phase
    typedef struct packed {
        // slave select
        logic sel;
        // 1 for write
        logic write;
        // transfer size
        hsize_e size;
        // byte address
        logic [ADDR_W-1:0] addr;
    } ahb_req_t;

    // live endpoint status from receiver and transmitter
    typedef struct packed {
        // last pid seen
        rx_pid_e rx_packet;
        // buffer has rx data waiting
        logic rx_data_ready;
        // receive in progress
        logic rx_active;
        logic rx_error;
        // transmit in progress
        logic tx_active;
        logic tx_error;
    } usb_status_t;

endpackage

// File: src/usb_ahb_write_regs.sv
// write path: address phase capture, transmit data lanes, transmit command pulse, flush control
`timescale 1ns/10ps

module usb_ahb_write_regs (
    input  logic                            clk,
    input  logic                            n_rst,
    input  usb_ahb_pkg::ahb_req_t           req,
    input  logic [usb_ahb_pkg::DATA_W-1:0]  hwdata,
    output logic [usb_ahb_pkg::DATA_W-1:0]  tx_data,
    output usb_ahb_pkg::tx_cmd_e            tx_packet,
    output logic                            store_tx_data,
    output logic                            clear
);

    // address phase held over into the data phase
    usb_ahb_pkg::ahb_req_t req_q;

    // byte offset inside the data window
    logic [usb_ahb_pkg::ADDR_W-1:0] offset;

    // write decode for the data phase
    logic wr_valid;
    logic wr_data_win;
    logic wr_tx_ctrl;
    logic wr_flush;

    // command code carried in the low bits of hwdata
    usb_ahb_pkg::tx_cmd_e cmd_code;
    logic cmd_upper_zero;

    // next state
    logic [usb_ahb_pkg::DATA_W-1:0] tx_data_next;
    usb_ahb_pkg::tx_cmd_e           tx_packet_next;
    logic                           store_next;
    logic                           clear_next;

    // capture address phase at E0
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            req_q <= '0;
        end else begin
            req_q <= req;
        end
    end

    // size 0 writes nothing
    assign wr_valid    = req_q.sel && req_q.write && (req_q.size != 2'b00);
    assign wr_data_win = wr_valid && (req_q.addr < usb_ahb_pkg::REG_STATUS);
    assign wr_tx_ctrl  = wr_valid && (req_q.addr == usb_ahb_pkg::REG_TX_CTRL);
    assign wr_flush    = wr_valid && (req_q.addr == usb_ahb_pkg::REG_FLUSH);

    assign offset = req_q.addr - usb_ahb_pkg::REG_DATA;

    // transmit data lane merge
    always_comb begin
        tx_data_next = tx_data;
        if (wr_data_win) begin
            case (req_q.size)
                usb_ahb_pkg::SIZE_WORD: begin
                    tx_data_next = hwdata;
                end
                usb_ahb_pkg::SIZE_HALF: begin
                    // offsets 2 and 3 land in the upper half
                    if (offset[1]) begin
                        tx_data_next[31:16] = hwdata[15:0];
                    end else begin
                        tx_data_next[15:0] = hwdata[15:0];
                    end
                end
                usb_ahb_pkg::SIZE_BYTE: begin
                    // low byte of hwdata into lane offset
                    tx_data_next[{offset[1:0], 3'b000} +: 8] = hwdata[7:0];
                end
                default: begin
                    tx_data_next = tx_data;
                end
            endcase
        end
    end

    // only an exact command value counts
    assign cmd_code       = usb_ahb_pkg::tx_cmd_e'(hwdata[2:0]);
    assign cmd_upper_zero = (hwdata[usb_ahb_pkg::DATA_W-1:3] == '0);

    // command pulse, defaults back to none every cycle
    always_comb begin
        tx_packet_next = usb_ahb_pkg::TX_NONE;
        store_next     = 1'b0;
        if (wr_tx_ctrl && cmd_upper_zero) begin
            case (cmd_code)
                usb_ahb_pkg::TX_DATA: begin
                    // data packet also stores the word
                    tx_packet_next = usb_ahb_pkg::TX_DATA;
                    store_next     = 1'b1;
                end
                usb_ahb_pkg::TX_ACK,
                usb_ahb_pkg::TX_NAK,
                usb_ahb_pkg::TX_STALL: begin
                    tx_packet_next = cmd_code;
                end
                default: begin
                    tx_packet_next = usb_ahb_pkg::TX_NONE;
                end
            endcase
        end
    end

    // flush level holds until rewritten
    assign clear_next = wr_flush ? hwdata[0] : clear;

    // register updates at E1
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            tx_data       <= '0;
            tx_packet     <= usb_ahb_pkg::TX_NONE;
            store_tx_data <= 1'b0;
            clear         <= 1'b0;
        end else begin
            tx_data       <= tx_data_next;
            tx_packet     <= tx_packet_next;
            store_tx_data <= store_next;
            clear         <= clear_next;
        end
    end

    // store strobe only alongside a data packet command
    a_store_is_data : assert property (@(posedge clk) disable iff (!n_rst)
        store_tx_data |-> (tx_packet == usb_ahb_pkg::TX_DATA))
        else $error("store_tx_data without TX_DATA command");

    // transmitter never sees a code outside the command set
    a_tx_cmd_defined : assert property (@(posedge clk) disable iff (!n_rst)
        tx_packet inside {usb_ahb_pkg::TX_NONE, usb_ahb_pkg::TX_DATA, usb_ahb_pkg::TX_ACK,
                          usb_ahb_pkg::TX_NAK, usb_ahb_pkg::TX_STALL})
        else $error("tx_packet holds an undefined code");

endmodule

// File: src/usb_ahb_read_resp.sv
// read path: status words, lane select read mux, error response, fetch strobe, hsize delay
`timescale 1ns/10ps

module usb_ahb_read_resp #(
    parameter int OCC_WIDTH = 6
) (
    input  logic                            clk,
    input  logic                            n_rst,
    input  usb_ahb_pkg::ahb_req_t           req,
    input  usb_ahb_pkg::usb_status_t        status,
    input  logic [OCC_WIDTH-1:0]            buffer_occupancy,
    input  logic [usb_ahb_pkg::DATA_W-1:0]  rx_data,
    input  usb_ahb_pkg::tx_cmd_e            tx_packet,
    input  logic                            clear,
    output logic [usb_ahb_pkg::DATA_W-1:0]  hrdata,
    output logic                            hresp,
    output logic                            get_rx_data,
    output logic [1:0]                      hsize_out
);

    // assembled register words
    logic [usb_ahb_pkg::DATA_W-1:0] status_word;
    logic [usb_ahb_pkg::DATA_W-1:0] error_word;
    logic [usb_ahb_pkg::DATA_W-1:0] occ_word;

    // window decode
    logic [usb_ahb_pkg::DATA_W-1:0] reg_word;
    logic [usb_ahb_pkg::ADDR_W-1:0] reg_base;
    logic [usb_ahb_pkg::ADDR_W-1:0] offset;
    logic                           win_hit;

    // read mux result and qualifiers
    logic [usb_ahb_pkg::DATA_W-1:0] rd_data;
    logic                           rd_valid;
    logic                           fetch_next;

    // error decode
    logic unused_addr;
    logic ro_addr;

    // first stage of hsize delay
    logic [1:0] size_d1;

    // pick lanes of a register word, result right aligned
    function automatic logic [usb_ahb_pkg::DATA_W-1:0] lane_select(
        input logic [usb_ahb_pkg::DATA_W-1:0] word,
        input usb_ahb_pkg::hsize_e            size,
        input logic [1:0]                     off
    );
        logic [usb_ahb_pkg::DATA_W-1:0] result;
        result = '0;
        case (size)
            usb_ahb_pkg::SIZE_WORD: result = word;
            // half that holds the offset
            usb_ahb_pkg::SIZE_HALF: result[15:0] = off[1] ? word[31:16] : word[15:0];
            usb_ahb_pkg::SIZE_BYTE: result[7:0] = word[{off, 3'b000} +: 8];
            default: result = '0;
        endcase
        return result;
    endfunction

    // status word, pid decoded to one-hot flags
    always_comb begin
        status_word    = '0;
        status_word[0] = status.rx_data_ready;
        case (status.rx_packet)
            usb_ahb_pkg::RX_IN:  status_word[1] = 1'b1;
            usb_ahb_pkg::RX_OUT: status_word[2] = 1'b1;
            usb_ahb_pkg::RX_ACK: status_word[3] = 1'b1;
            usb_ahb_pkg::RX_NAK: status_word[4] = 1'b1;
            default: status_word[4:1] = 4'b0000;
        endcase
        status_word[8] = status.rx_active;
        status_word[9] = status.tx_active;
    end

    // rx error in byte 0, tx error in byte 1
    assign error_word = {{(usb_ahb_pkg::DATA_W-9){1'b0}}, status.tx_error, 7'b0000000,
                         status.rx_error};

    assign occ_word = {{(usb_ahb_pkg::DATA_W-OCC_WIDTH){1'b0}}, buffer_occupancy};

    // which windowed register, and its base
    always_comb begin
        reg_word = '0;
        reg_base = usb_ahb_pkg::REG_DATA;
        win_hit  = 1'b1;
        if (req.addr < usb_ahb_pkg::REG_STATUS) begin
            reg_word = rx_data;
            reg_base = usb_ahb_pkg::REG_DATA;
        end else if (req.addr < usb_ahb_pkg::REG_ERROR) begin
            reg_word = status_word;
            reg_base = usb_ahb_pkg::REG_STATUS;
        end else if (req.addr < usb_ahb_pkg::REG_OCC) begin
            reg_word = error_word;
            reg_base = usb_ahb_pkg::REG_ERROR;
        end else if (req.addr == usb_ahb_pkg::REG_OCC) begin
            reg_word = occ_word;
            reg_base = usb_ahb_pkg::REG_OCC;
        end else begin
            win_hit = 1'b0;
        end
    end

    // same lane rule for every window
    assign offset = req.addr - reg_base;

    // read mux
    always_comb begin
        rd_data = '0;
        if (win_hit) begin
            rd_data = lane_select(reg_word, req.size, offset[1:0]);
        end else if (req.addr == usb_ahb_pkg::REG_TX_CTRL) begin
            // control registers ignore size
            rd_data = {{(usb_ahb_pkg::DATA_W-3){1'b0}}, tx_packet};
        end else if (req.addr == usb_ahb_pkg::REG_FLUSH) begin
            rd_data = {{(usb_ahb_pkg::DATA_W-1){1'b0}}, clear};
        end
    end

    assign rd_valid = req.sel && !req.write;

    // holes 9..11 and 14..15
    assign unused_addr = ((req.addr > usb_ahb_pkg::REG_OCC) &&
                          (req.addr < usb_ahb_pkg::REG_TX_CTRL)) ||
                         (req.addr > usb_ahb_pkg::REG_FLUSH);
    // status, error and occupancy are read only
    assign ro_addr = (req.addr >= usb_ahb_pkg::REG_STATUS) &&
                     (req.addr <= usb_ahb_pkg::REG_OCC);

    // address phase error, combinational
    assign hresp = req.sel && (unused_addr || (req.write && ro_addr));

    // fetch next word from buffer on a data window read
    assign fetch_next = rd_valid && (req.addr < usb_ahb_pkg::REG_STATUS) &&
                        status.rx_data_ready;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            hrdata      <= '0;
            get_rx_data <= 1'b0;
            size_d1     <= 2'b00;
            hsize_out   <= 2'b00;
        end else begin
            // zero whenever no read was sampled
            hrdata      <= rd_valid ? rd_data : '0;
            get_rx_data <= fetch_next;
            // two stage size delay
            size_d1     <= req.size;
            hsize_out   <= size_d1;
        end
    end

    // strobe only follows a read sampled while data was ready
    a_fetch_after_read : assert property (@(posedge clk) disable iff (!n_rst)
        get_rx_data |-> $past(status.rx_data_ready && req.sel && !req.write))
        else $error("get_rx_data without a preceding ready read");

endmodule

// File: src/usb_ahb_slave.sv
// top level: bus and endpoint packing, write path and read path instances
`timescale 1ns/10ps

module usb_ahb_slave #(
    parameter int OCC_WIDTH = 6
) (
    input  logic                            clk,
    input  logic                            n_rst,
    // ahb-lite bus
    input  logic                            hsel,
    input  logic                            hwrite,
    input  logic [1:0]                      hsize,
    input  logic [usb_ahb_pkg::ADDR_W-1:0]  haddr,
    input  logic [usb_ahb_pkg::DATA_W-1:0]  hwdata,
    output logic [usb_ahb_pkg::DATA_W-1:0]  hrdata,
    output logic                            hresp,
    output logic [1:0]                      hsize_out,
    // receiver
    input  logic [2:0]                      rx_packet,
    input  logic                            rx_data_ready,
    input  logic                            rx_transfer_active,
    input  logic                            rx_error,
    // transmitter
    input  logic                            tx_transfer_active,
    input  logic                            tx_error,
    output logic [2:0]                      tx_packet,
    // data buffer
    input  logic [OCC_WIDTH-1:0]            buffer_occupancy,
    input  logic [usb_ahb_pkg::DATA_W-1:0]  rx_data,
    output logic                            get_rx_data,
    output logic                            store_tx_data,
    output logic                            clear,
    output logic [usb_ahb_pkg::DATA_W-1:0]  tx_data
);

    // bundled bus request and endpoint status
    usb_ahb_pkg::ahb_req_t    req;
    usb_ahb_pkg::usb_status_t status;

    // command from write path, also read back
    usb_ahb_pkg::tx_cmd_e tx_cmd;

    assign req.sel   = hsel;
    assign req.write = hwrite;
    assign req.size  = usb_ahb_pkg::hsize_e'(hsize);
    assign req.addr  = haddr;

    assign status.rx_packet     = usb_ahb_pkg::rx_pid_e'(rx_packet);
    assign status.rx_data_ready = rx_data_ready;
    assign status.rx_active     = rx_transfer_active;
    assign status.rx_error      = rx_error;
    assign status.tx_active     = tx_transfer_active;
    assign status.tx_error      = tx_error;

    assign tx_packet = tx_cmd;

    // registers written over the bus
    usb_ahb_write_regs u_write_regs (
        .clk           (clk),
        .n_rst         (n_rst),
        .req           (req),
        .hwdata        (hwdata),
        .tx_data       (tx_data),
        .tx_packet     (tx_cmd),
        .store_tx_data (store_tx_data),
        .clear         (clear)
    );

    // read data, error response and buffer fetch
    usb_ahb_read_resp #(
        .OCC_WIDTH (OCC_WIDTH)
    ) u_read_resp (
        .clk              (clk),
        .n_rst            (n_rst),
        .req              (req),
        .status           (status),
        .buffer_occupancy (buffer_occupancy),
        .rx_data          (rx_data),
        .tx_packet        (tx_cmd),
        .clear            (clear),
        .hrdata           (hrdata),
        .hresp            (hresp),
        .get_rx_data      (get_rx_data),
        .hsize_out        (hsize_out)
    );

endmodule

// File: verification/tb_usb_ahb_slave.sv
// testbench with clock, reset, dut, bus tasks, directed tests and error summary
`timescale 1ns/10ps

module tb_usb_ahb_slave;

    logic clk, n_rst, hsel, hwrite, hresp, get_rx_data, store_tx_data, clear;
    logic rx_data_ready, rx_transfer_active, rx_error, tx_transfer_active, tx_error;
    logic [1:0] hsize, hsize_out;
    logic [2:0] rx_packet, tx_packet;
    logic [3:0] haddr;
    logic [5:0] buffer_occupancy;
    logic [31:0] hwdata, hrdata, rx_data, tx_data;
    int errors;
    integer seed;

    usb_ahb_slave #(.OCC_WIDTH(6)) u_usb_ahb_slave (.*);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        assert (actual === expected) else begin
            $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    // lanes a read should return right aligned
    function automatic logic [31:0] expect_lanes(input logic [31:0] word,
                                                 input logic [1:0] size, input logic [1:0] off);
        case (size)
            2'd3: return word;
            2'd2: return (word >> (off[1] ? 16 : 0)) & 32'h0000_ffff;
            2'd1: return (word >> (off * 8)) & 32'h0000_00ff;
            default: return 32'h0;
        endcase
    endfunction

    // address phase then hwdata phase; returns just after E1
    task automatic ahb_write(input logic [3:0] addr, input logic [1:0] size,
                             input logic [31:0] data);
        hsel = 1'b1;
        hwrite = 1'b1;
        hsize = size;
        haddr = addr;
        @(posedge clk);
        #1;
        hsel = 1'b0;
        hwdata = data;
        @(posedge clk);
        #1;
    endtask

    // returns just after E0 with hrdata and the fetch strobe
    task automatic ahb_read(input logic [3:0] addr, input logic [1:0] size,
                            output logic [31:0] data, output logic strobe);
        hsel = 1'b1;
        hwrite = 1'b0;
        hsize = size;
        haddr = addr;
        @(posedge clk);
        #1;
        hsel = 1'b0;
        data = hrdata;
        strobe = get_rx_data;
    endtask

    // model follows the lane rule; word writes come first so later writes merge into it
    task automatic tx_data_lane_writes();
        logic [31:0] model;
        logic [31:0] data;
        model = 32'h0;
        for (int size = 3; size >= 1; size--) begin
            for (int off = 0; off < 4; off++) begin
                data = $random(seed);
                case (size)
                    3: model = data;
                    2: model[(off / 2) * 16 +: 16] = data[15:0];
                    default: model[off * 8 +: 8] = data[7:0];
                endcase
                ahb_write(4'(off), 2'(size), data);
                check_equal(tx_data, model, "tx_data after lane write");
            end
        end
    endtask

    task automatic tx_command_pulses();
        int wait_cnt;
        for (int code = 1; code <= 5; code++) begin
            // code 5 stands for the undefined value 7
            hsel = 1'b1;
            hwrite = 1'b1;
            hsize = 2'd3;
            haddr = usb_ahb_pkg::REG_TX_CTRL;
            @(posedge clk);
            #1;
            hsel = 1'b0;
            hwdata = (code == 5) ? 32'd7 : 32'(code);
            wait_cnt = 0;
            while (tx_packet == 3'd0 && wait_cnt < 4) begin
                @(posedge clk);
                #1;
                wait_cnt++;
            end
            if (code == 5) begin
                check_equal(32'(tx_packet), 32'd0, "tx_packet after value 7");
            end else if (tx_packet == 3'd0) begin
                $display("timed out waiting for the tx_packet pulse of command %0d", code);
                errors++;
            end else begin
                check_equal(32'(wait_cnt), 32'd1, "tx_packet pulse cycle");
                check_equal(32'(tx_packet), 32'(code), "tx_packet code");
                check_equal(32'(store_tx_data), 32'(code == 1), "store_tx_data with command");
                @(posedge clk);
                #1;
                check_equal(32'({tx_packet, store_tx_data}), 32'd0, "pulse longer than a cycle");
            end
        end
    endtask

    task automatic flush_control();
        logic [31:0] rd;
        logic strobe;
        for (int v = 1; v >= 0; v--) begin
            ahb_write(usb_ahb_pkg::REG_FLUSH, 2'd3, 32'(v));
            // level must hold while idle
            repeat (3) begin
                check_equal(32'(clear), 32'(v), "clear level");
                @(posedge clk);
                #1;
            end
            ahb_read(usb_ahb_pkg::REG_FLUSH, 2'd1, rd, strobe);
            check_equal(rd, 32'(v), "flush read back");
            check_equal(32'(strobe), 32'd0, "get_rx_data on flush read");
        end
    endtask

    task automatic rx_data_reads();
        logic [31:0] rd;
        logic strobe;
        for (int rdy = 0; rdy < 2; rdy++) begin
            for (int size = 1; size <= 3; size++) begin
                for (int off = 0; off < 4; off++) begin
                    rx_data = $random(seed);
                    rx_data_ready = 1'(rdy);
                    ahb_read(4'(off), 2'(size), rd, strobe);
                    check_equal(rd, expect_lanes(rx_data, 2'(size), 2'(off)), "rx_data lanes");
                    check_equal(32'(strobe), 32'(rdy), "get_rx_data on read");
                    // strobe and hrdata drop in the idle cycle
                    @(posedge clk);
                    #1;
                    check_equal({hrdata[31:1], hrdata[0] | get_rx_data}, 32'd0, "idle outputs");
                end
            end
        end
    endtask

    task automatic status_reads();
        logic [31:0] rd;
        logic [31:0] st;
        logic [31:0] expected;
        logic strobe;
        for (int n = 0; n < 8; n++) begin
            {rx_packet, rx_data_ready, rx_transfer_active, rx_error,
             tx_transfer_active, tx_error} = 8'($random(seed));
            buffer_occupancy = 6'($random(seed));
            // one-hot pid flags in, out, ack, nak
            st = {22'h0, tx_transfer_active, rx_transfer_active, 3'h0, rx_packet == 3'd6,
                  rx_packet == 3'd5, rx_packet == 3'd1, rx_packet == 3'd2, rx_data_ready};
            for (int a = 4; a <= 8; a++) begin
                for (int size = 1; size <= 3; size++) begin
                    ahb_read(4'(a), 2'(size), rd, strobe);
                    if (a < 6) begin
                        expected = expect_lanes(st, 2'(size), 2'(a - 4));
                    end else if (a < 8) begin
                        expected = expect_lanes({23'h0, tx_error, 7'h0, rx_error},
                                                2'(size), 2'(a - 6));
                    end else begin
                        expected = expect_lanes({26'h0, buffer_occupancy}, 2'(size), 2'd0);
                    end
                    check_equal(rd, expected, "status, error or occupancy read");
                    // no buffer fetch outside the data window
                    check_equal(32'(strobe), 32'd0, "get_rx_data outside data window");
                end
            end
        end
    endtask

    task automatic error_and_size_delay();
        logic [1:0] hist [12];
        logic expect_err;
        hwdata = 32'h0;
        for (int a = 0; a < 16; a++) begin
            for (int w = 0; w < 2; w++) begin
                expect_err = (a >= 9 && a <= 11) || a >= 14 || (w == 1 && a >= 4 && a <= 8);
                hsel = 1'b1;
                hwrite = 1'(w);
                hsize = 2'd3;
                haddr = 4'(a);
                #1;
                check_equal(32'(hresp), 32'(expect_err), "hresp in address phase");
                @(posedge clk);
                #1;
                hsel = 1'b0;
            end
        end
        // size seen at edge k shows on hsize_out after edge k+1
        for (int i = 0; i < 12; i++) begin
            if (i >= 2) begin
                check_equal(32'(hsize_out), 32'(hist[i - 2]), "hsize_out two cycle delay");
            end
            hist[i] = 2'($random(seed));
            hsize = hist[i];
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        seed = 98;
        errors = 0;
        n_rst = 1'b0;
        {hsel, hwrite, hsize, haddr, hwdata} = '0;
        {rx_packet, rx_data_ready, rx_transfer_active, rx_error} = '0;
        {tx_transfer_active, tx_error, buffer_occupancy, rx_data} = '0;
        repeat (2) @(posedge clk);
        #1;
        n_rst = 1'b1;
        check_equal({hrdata[31:1], hrdata[0] | clear}, 32'd0, "hrdata or clear after reset");
        check_equal(32'({tx_packet, store_tx_data, get_rx_data, hsize_out}), 32'd0,
                    "strobes or hsize_out after reset");
        check_equal(tx_data, 32'd0, "tx_data after reset");
        tx_data_lane_writes();
        tx_command_pulses();
        flush_control();
        rx_data_reads();
        status_reads();
        error_and_size_delay();
        $display("error count %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: usb_ahb_slave.f
src/usb_ahb_pkg.sv
src/usb_ahb_write_regs.sv
src/usb_ahb_read_resp.sv
src/usb_ahb_slave.sv
verification/tb_usb_ahb_slave.sv

// File: run_sim.sh
#!/bin/sh
# build and run with verilator, the verdict comes from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_usb_ahb_slave \
    -f usb_ahb_slave.f > sim.log 2>&1 \
    && ./obj_dir/Vtb_usb_ahb_slave >> sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log
grep -q "Finished with errors" sim.log && echo "FAIL" && exit 1
grep -q "Finished with no errors" sim.log && echo "PASS" && exit 0
echo "FAIL"
exit 1
